// ==== branchFourToOne.sv ====
// first-taken slot search, delay slot trimming and destination select
module branchFourToOne (
    input  logic [3:0]       originEnable_i,
    input  logic [3:0]       predTake_i,
    input  logic [3:0][31:0] predDest_i,
    input  logic [31:0]      vAddr_i,
    input  logic             delaySlotOnly_i,
    output logic [3:0]       actualEnable_o,
    output logic [3:0]       firstTaken_o,     // one-hot or zero
    output logic             validTake_o,
    output logic [31:0]      validDest_o,
    output logic [31:0]      fifthVAddr_o,
    output logic             needDelaySlot_o
);
    logic [3:0]  takenSlot;
    logic [3:0]  keepMask;
    logic [3:0]  lowestEnable;
    logic [31:0] takenDest;

    assign fifthVAddr_o = {vAddr_i[31:4], 4'b0000} + 32'd16;

    // a delay-slot-only packet carries no branch decision of its own
    assign takenSlot    = delaySlotOnly_i ? 4'b0000 : (originEnable_i & predTake_i);
    assign firstTaken_o = takenSlot & (~takenSlot + 4'd1);    // lowest set bit
    assign lowestEnable = originEnable_i & (~originEnable_i + 4'd1);

    // ----------------------------------------
    // enable trimming
    // ----------------------------------------
    // slots up to k+1; wraps to all ones when nothing is taken
    assign keepMask = (firstTaken_o - 4'd1) | firstTaken_o | {firstTaken_o[2:0], 1'b0};

    assign actualEnable_o = delaySlotOnly_i ? lowestEnable : (originEnable_i & keepMask);

    always_comb begin
        takenDest = '0;
        for (int i = 0; i < 4; i++) begin
            takenDest = takenDest | ({32{firstTaken_o[i]}} & predDest_i[i]);
        end
    end

    assign validTake_o     = |firstTaken_o;
    assign validDest_o     = validTake_o ? takenDest : fifthVAddr_o;  // fall through
    assign needDelaySlot_o = firstTaken_o[3];   // delay slot sits in the next packet

    firstTakenOneHot: assert final ($onehot0(firstTaken_o))
        else $error("first taken select is not one-hot");

endmodule

// ==== branchPkg.sv ====
// branch class, take-select and return-stack repair enums, MIPS opcode and function codes
package branchPkg;

    // ----------------------------------------
    // predecode results
    // ----------------------------------------
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,   // not a control transfer
        BR_COND = 2'd1,   // beq/bne/blez/bgtz/regimm
        BR_JUMP = 2'd2,   // j, jal
        BR_JREG = 2'd3    // jr, jalr
    } brClass_e;

    typedef enum logic [1:0] {
        TS_NONE = 2'd0,
        TS_PHT  = 2'd1,   // direction from the btb bit
        TS_MUST = 2'd2    // unconditional
    } takeSel_e;

    // return stack fixup sent with a redirect
    typedef enum logic [1:0] {
        RA_NONE = 2'd0,
        RA_PUSH = 2'd1,
        RA_POP  = 2'd2,
        RA_FIX  = 2'd3
    } repairAction_e;

    // ----------------------------------------
    // instruction encodings
    // ----------------------------------------
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111
    } opcode_e;

    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001
    } funct_e;

    localparam logic [4:0] RA_REG = 5'd31;  // link register

endpackage

// ==== branchSelectCheck.sv ====
// branch select and btb check, queue packet build and redirect request
module branchSelectCheck (
    input  fetchPkg::fetchPkt_t     fetch_i,
    output fetchPkg::queuePkt_t     queuePkt_o,
    output logic                    queueValid_o,
    output fetchPkg::redirectInfo_t redirect_o
);
    import fetchPkg::*;
    import branchPkg::*;

    logic [3:0][31:0] inst;             // masked on exception
    brClass_e [3:0]   slotClass;
    takeSel_e [3:0]   takeSel;
    logic [3:0]       slotTake;
    logic [3:0]       isBranch;
    logic [3:0]       actualEnable;
    logic [3:0]       firstTaken;
    logic             validTake;
    logic [31:0]      validDest;
    logic [31:0]      fifthVAddr;
    logic             needDelaySlot;
    logic [3:0][3:0]  select;
    logic [3:0]       instEnable;
    logic [2:0]       instNum;
    logic [31:0]      firstBranchInst;
    logic             isEnableSame;
    logic             isPredictSame;
    logic             isDiffRes;
    repairAction_e    repairAction;
    redirectInfo_t    redirect;

    function automatic logic [1:0] slotIndex(input logic [3:0] oneHot);
        slotIndex = {oneHot[3] | oneHot[2], oneHot[3] | oneHot[1]};
    endfunction

    // ----------------------------------------
    // own prediction
    // ----------------------------------------
    assign inst = fetch_i.hasException ? '0 : fetch_i.inst;

    takeDestDecoder u_takeDestDecoder (
        .inst_i   (inst),
        .class_o  (slotClass),
        .takeSel_o(takeSel)
    );

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            slotTake[i] = (takeSel[i] == TS_MUST)
                          || (takeSel[i] == TS_PHT && fetch_i.btbPredTake[i]);
            isBranch[i] = slotClass[i] != BR_NONE;
        end
    end

    branchFourToOne u_branchFourToOne (
        .originEnable_i (fetch_i.originEnable),
        .predTake_i     (slotTake),
        .predDest_i     (fetch_i.btbPredDest),
        .vAddr_i        (fetch_i.vAddr),
        .delaySlotOnly_i(fetch_i.delaySlotOnly),
        .actualEnable_o (actualEnable),
        .firstTaken_o   (firstTaken),
        .validTake_o    (validTake),
        .validDest_o    (validDest),
        .fifthVAddr_o   (fifthVAddr),
        .needDelaySlot_o(needDelaySlot)
    );

    // compare against what the btb already did
    assign isEnableSame  = actualEnable == fetch_i.btbInstEnable;
    assign isPredictSame = (!validTake && !fetch_i.btbValidTake)
                           || (validTake && fetch_i.btbValidTake
                               && validDest == fetch_i.btbValidDest);
    assign isDiffRes = fetch_i.valid && !fetch_i.delaySlotOnly
                       && !(isEnableSame && isPredictSame);

    // ----------------------------------------
    // queue packet
    // ----------------------------------------
    instCompressor u_instCompressor (
        .actualEnable_i(actualEnable),
        .select_o      (select),
        .instEnable_o  (instEnable),
        .instNum_o     (instNum)
    );

    always_comb begin
        queuePkt_o.inst     = '0;
        queuePkt_o.predTake = '0;
        queuePkt_o.predDest = '0;
        for (int j = 0; j < 4; j++) begin
            for (int i = 0; i < 4; i++) begin
                if (select[j][i]) begin
                    queuePkt_o.inst[j]     = inst[i];
                    queuePkt_o.predTake[j] = slotTake[i];
                    queuePkt_o.predDest[j] = fetch_i.btbPredDest[i];
                end
            end
        end
        queuePkt_o.instEnable   = instEnable;
        queuePkt_o.instNum      = instNum;
        queuePkt_o.basePC       = {fetch_i.vAddr[31:4], slotIndex(select[0]), 2'b00};
        queuePkt_o.hasException = fetch_i.hasException;
        queuePkt_o.excCode      = fetch_i.excCode;
    end

    assign queueValid_o = fetch_i.valid && (|actualEnable);   // empty packets use no credit

    // ----------------------------------------
    // redirect
    // ----------------------------------------
    always_comb begin
        firstBranchInst = '0;
        for (int i = 0; i < 4; i++) begin
            firstBranchInst = firstBranchInst | ({32{firstTaken[i]}} & inst[i]);
        end
    end

    repairDecoder u_repairDecoder (
        .inst_i     (firstBranchInst),
        .isDiffRes_i(isDiffRes),
        .action_o   (repairAction)
    );

    always_comb begin
        redirect.redirect       = isDiffRes;
        redirect.needDelaySlot  = needDelaySlot;
        redirect.delaySlotTaken = fetch_i.delaySlotOnly;
        redirect.errVAddr       = {fetch_i.vAddr[31:4], slotIndex(firstTaken), 2'b00};
        redirect.correctTake    = validTake;
        redirect.correctDest    = validDest;
        redirect.fifthVAddr     = fifthVAddr;
        redirect.repairAction   = repairAction;
    end

    assign redirect_o = fetch_i.valid ? redirect : '0;

    // the selected slot must have been predecoded as a branch
    takenIsBranch: assert final (!fetch_i.valid || (firstTaken & ~isBranch) == 4'b0000)
        else $error("taken slot without a branch class");

endmodule

// ==== compile.f ====
branchPkg.sv
fetchPkg.sv
takeDestDecoder.sv
branchFourToOne.sv
instCompressor.sv
repairDecoder.sv
branchSelectCheck.sv
fetchCreditStage.sv
fetchFrontTop.sv
tbFetchFront.sv

// ==== fetchCreditStage.sv ====
// output registers toward the instruction queue with the credit counter
module fetchCreditStage #(
    parameter int CREDITS = 4
) (
    input  logic                    clk,
    input  logic                    arstN_i,
    input  fetchPkg::queuePkt_t     queuePkt_i,
    input  logic                    queueValid_i,
    input  fetchPkg::redirectInfo_t redirect_i,
    input  logic                    fetchValid_i,
    input  logic                    creditReturn_i,
    output fetchPkg::queuePkt_t     queuePkt_o,
    output logic                    queueValid_o,
    output fetchPkg::redirectInfo_t redirect_o,
    output logic                    creditAvail_o
);
    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] creditCnt;
    logic [CW-1:0] creditNext;

    // spend on send, refill on return, both in one cycle is fine
    assign creditNext    = creditCnt - CW'(queueValid_i) + CW'(creditReturn_i);
    assign creditAvail_o = creditCnt != '0;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            queueValid_o <= 1'b0;
            redirect_o   <= '0;
            creditCnt    <= CW'(CREDITS);
        end else begin
            queueValid_o <= queueValid_i;
            redirect_o   <= redirect_i;
            creditCnt    <= creditNext;
        end
    end

    always_ff @(posedge clk) begin
        if (queueValid_i) begin
            queuePkt_o <= queuePkt_i;
        end
    end

    // ----------------------------------------
    // credit protocol checks
    // ----------------------------------------
    creditBound: assert property (@(posedge clk) disable iff (!arstN_i)
        creditCnt <= CW'(CREDITS));
    fetchNeedsCredit: assert property (@(posedge clk) disable iff (!arstN_i)
        fetchValid_i |-> creditAvail_o);
    noReturnWhenFull: assert property (@(posedge clk) disable iff (!arstN_i)
        creditReturn_i |-> creditCnt != CW'(CREDITS));

endmodule

// ==== fetchFrontTop.sv ====
// branch select/check stage followed by the credit output stage
module fetchFrontTop #(
    parameter int CREDITS = 4     // instruction queue depth
) (
    input  logic                    clk,
    input  logic                    arstN_i,
    input  fetchPkg::fetchPkt_t     fetch_i,
    input  logic                    creditReturn_i,
    output logic                    creditAvail_o,
    output fetchPkg::queuePkt_t     queuePkt_o,
    output logic                    queueValid_o,
    output fetchPkg::redirectInfo_t redirect_o
);
    import fetchPkg::*;

    queuePkt_t     checkPkt;
    logic          checkValid;
    redirectInfo_t checkRedirect;

    branchSelectCheck u_branchSelectCheck (
        .fetch_i     (fetch_i),
        .queuePkt_o  (checkPkt),
        .queueValid_o(checkValid),
        .redirect_o  (checkRedirect)
    );

    fetchCreditStage #(
        .CREDITS(CREDITS)
    ) u_fetchCreditStage (
        .clk           (clk),
        .arstN_i       (arstN_i),
        .queuePkt_i    (checkPkt),
        .queueValid_i  (checkValid),
        .redirect_i    (checkRedirect),
        .fetchValid_i  (fetch_i.valid),
        .creditReturn_i(creditReturn_i),
        .queuePkt_o    (queuePkt_o),
        .queueValid_o  (queueValid_o),
        .redirect_o    (redirect_o),
        .creditAvail_o (creditAvail_o)
    );

endmodule

// ==== fetchPkg.sv ====
// packet structs for the fetch input, the instruction queue and the redirect request
package fetchPkg;

    // ----------------------------------------
    // from the earlier fetch stage
    // ----------------------------------------
    typedef struct packed {
        logic             valid;
        logic [31:0]      vAddr;          // address of first enabled word
        logic [3:0]       originEnable;
        logic [3:0][31:0] inst;
        logic [3:0]       btbPredTake;
        logic [3:0][31:0] btbPredDest;
        logic [3:0]       btbInstEnable;  // enables after btb trimming
        logic             btbValidTake;
        logic [31:0]      btbValidDest;
        logic             delaySlotOnly;  // only the pending delay slot
        logic             hasException;
        logic [4:0]       excCode;
    } fetchPkt_t;

    // toward the instruction queue, slots packed low
    typedef struct packed {
        logic [3:0][31:0] inst;
        logic [3:0]       predTake;
        logic [3:0][31:0] predDest;
        logic [3:0]       instEnable;
        logic [2:0]       instNum;
        logic [31:0]      basePC;
        logic             hasException;
        logic [4:0]       excCode;
    } queuePkt_t;

    typedef struct packed {
        logic                     redirect;
        logic                     needDelaySlot;
        logic                     delaySlotTaken;
        logic [31:0]              errVAddr;
        logic                     correctTake;
        logic [31:0]              correctDest;
        logic [31:0]              fifthVAddr;
        branchPkg::repairAction_e repairAction;
    } redirectInfo_t;

endpackage

// ==== instCompressor.sv ====
// packs enabled slots toward slot 0 and counts them
module instCompressor (
    input  logic [3:0]      actualEnable_i,
    output logic [3:0][3:0] select_o,        // [output slot][input slot]
    output logic [3:0]      instEnable_o,
    output logic [2:0]      instNum_o
);
    logic [2:0] count;

    // output slot j takes the j-th enabled input
    always_comb begin
        count    = 3'd0;
        select_o = '0;
        for (int i = 0; i < 4; i++) begin
            if (actualEnable_i[i]) begin
                select_o[count[1:0]][i] = 1'b1;
                count = count + 3'd1;
            end
        end
    end

    assign instNum_o = count;

    // thermometer fill from the bottom
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            instEnable_o[j] = 3'(j) < count;
        end
    end

endmodule

// ==== repairDecoder.sv ====
// return stack repair action for the branch that caused a redirect
module repairDecoder (
    input  logic [31:0]              inst_i,
    input  logic                     isDiffRes_i,
    output branchPkg::repairAction_e action_o
);
    import branchPkg::*;

    logic isJal;
    logic isJalr;
    logic isJrRa;

    assign isJal  = inst_i[31:26] == OP_JAL;
    assign isJalr = inst_i[31:26] == OP_SPECIAL && inst_i[5:0] == FN_JALR;
    assign isJrRa = inst_i[31:26] == OP_SPECIAL && inst_i[5:0] == FN_JR
                    && inst_i[25:21] == RA_REG;       // function return

    always_comb begin
        if (!isDiffRes_i) begin
            action_o = RA_NONE;
        end else if (isJal || isJalr) begin
            action_o = RA_PUSH;   // call
        end else if (isJrRa) begin
            action_o = RA_POP;
        end else begin
            action_o = RA_FIX;
        end
    end

endmodule

// ==== takeDestDecoder.sv ====
// predecode of four instruction words into branch classes and take-select codes
module takeDestDecoder (
    input  logic [3:0][31:0]          inst_i,
    output branchPkg::brClass_e [3:0] class_o,
    output branchPkg::takeSel_e [3:0] takeSel_o
);
    import branchPkg::*;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            class_o[i]   = BR_NONE;
            takeSel_o[i] = TS_NONE;
            case (inst_i[i][31:26])
                OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM: begin
                    class_o[i]   = BR_COND;
                    takeSel_o[i] = TS_PHT;   // direction comes from the btb
                end
                OP_J, OP_JAL: begin
                    class_o[i]   = BR_JUMP;
                    takeSel_o[i] = TS_MUST;
                end
                OP_SPECIAL: begin
                    // register jumps live in the function field
                    if (inst_i[i][5:0] == FN_JR || inst_i[i][5:0] == FN_JALR) begin
                        class_o[i]   = BR_JREG;
                        takeSel_o[i] = TS_MUST;
                    end
                end
                default: begin
                    class_o[i]   = BR_NONE;
                    takeSel_o[i] = TS_NONE;
                end
            endcase
        end
    end

endmodule

// ==== tbFetchFront.sv ====
// testbench for the fetch front end with reference model and credit-returning queue model
module tbFetchFront;
    import fetchPkg::*;
    import branchPkg::*;

    localparam int CREDITS = 4;
    localparam int PACKETS = 2000;
    localparam int PERIOD  = 4;

    // expected response for one sampled input cycle
    typedef struct packed {
        logic          qValid;
        queuePkt_t     q;
        redirectInfo_t r;
        logic [3:0]    actEn;   // surviving enables before compression
    } expOut_t;

    logic          clk;
    logic          arstN_i;
    fetchPkt_t     fetch;
    logic          creditReturn;
    logic          creditAvail;
    queuePkt_t     queuePkt;
    logic          queueValid;
    redirectInfo_t redirect;

    expOut_t expQ[$];
    int      errors;
    int      sent;
    int      accepted;      // packets that should reach the queue
    int      received;
    int      returned;
    int      held;          // packets sitting in the queue model
    int      modelCredit;
    bit      running;

    fetchFrontTop #(
        .CREDITS(CREDITS)
    ) dut_i (
        .clk           (clk),
        .arstN_i       (arstN_i),
        .fetch_i       (fetch),
        .creditReturn_i(creditReturn),
        .creditAvail_o (creditAvail),
        .queuePkt_o    (queuePkt),
        .queueValid_o  (queueValid),
        .redirect_o    (redirect)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic slotTakes(input logic [31:0] w, input logic btbTake);
        logic [5:0] op;
        op = w[31:26];
        if (op inside {6'd1, 6'd4, 6'd5, 6'd6, 6'd7}) begin
            return btbTake;     // regimm, beq..bgtz
        end
        if (op == 6'd2 || op == 6'd3) begin
            return 1'b1;        // j, jal
        end
        return op == 6'd0 && (w[5:0] == 6'h08 || w[5:0] == 6'h09);
    endfunction

    function automatic repairAction_e expectRepair(input logic [31:0] w);
        if (w[31:26] == 6'd3 || (w[31:26] == 6'd0 && w[5:0] == 6'h09)) begin
            return RA_PUSH;
        end
        if (w[31:26] == 6'd0 && w[5:0] == 6'h08 && w[25:21] == 5'd31) begin
            return RA_POP;      // return through ra
        end
        return RA_FIX;
    endfunction

    function automatic expOut_t model(input fetchPkt_t f);
        expOut_t          e;
        logic [3:0][31:0] w;
        logic [3:0]       take;
        logic [31:0]      base;
        logic [31:0]      dest;
        logic             same;
        logic             seenEn;
        int               k;
        int               n;
        int               first;
        e      = '0;
        w      = f.hasException ? '0 : f.inst;
        base   = {f.vAddr[31:4], 4'h0};
        seenEn = 1'b0;
        k      = -1;
        n      = 0;
        first  = -1;
        for (int i = 0; i < 4; i++) begin
            take[i] = slotTakes(w[i], f.btbPredTake[i]);
            if (k < 0 && !f.delaySlotOnly && f.originEnable[i] && take[i]) begin
                k = i;
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (f.delaySlotOnly) begin
                e.actEn[i] = f.originEnable[i] && !seenEn;   // lowest enabled only
            end else begin
                e.actEn[i] = f.originEnable[i] && (k < 0 || i <= k + 1);
            end
            seenEn = seenEn | f.originEnable[i];
        end
        dest = (k >= 0) ? f.btbPredDest[k] : base + 32'd16;
        for (int i = 0; i < 4; i++) begin
            if (e.actEn[i]) begin
                e.q.inst[n]       = w[i];
                e.q.predTake[n]   = take[i];
                e.q.predDest[n]   = f.btbPredDest[i];
                e.q.instEnable[n] = 1'b1;
                if (first < 0) begin
                    first = i;
                end
                n++;
            end
        end
        e.q.instNum      = 3'(n);
        e.q.basePC       = base + 32'(4 * (first < 0 ? 0 : first));
        e.q.hasException = f.hasException;
        e.q.excCode      = f.excCode;
        e.qValid         = f.valid && n > 0;
        same = e.actEn == f.btbInstEnable
               && ((k < 0 && !f.btbValidTake)
                   || (k >= 0 && f.btbValidTake && dest == f.btbValidDest));
        if (f.valid) begin
            e.r.redirect       = !f.delaySlotOnly && !same;
            e.r.needDelaySlot  = k == 3;
            e.r.delaySlotTaken = f.delaySlotOnly;
            e.r.errVAddr       = base + 32'(4 * (k < 0 ? 0 : k));
            e.r.correctTake    = k >= 0;
            e.r.correctDest    = dest;
            e.r.fifthVAddr     = base + 32'd16;
            e.r.repairAction   = e.r.redirect ? expectRepair(k < 0 ? 32'd0 : w[k]) : RA_NONE;
        end
        return e;
    endfunction

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    function automatic logic [31:0] randomInst();
        int          r;
        logic [31:0] w;
        r = $urandom_range(99);
        w = $urandom;
        if (r < 40) begin
            w[31:26] = 6'($urandom_range(63, 8));     // no control transfer
        end else if (r < 65) begin
            w[31:26] = ($urandom_range(4) == 0) ? 6'd1 : 6'($urandom_range(7, 4));
        end else if (r < 80) begin
            w[31:26] = 6'($urandom_range(3, 2));
        end else begin
            w[31:26] = 6'd0;
            w[5:0]   = ($urandom_range(1) == 1) ? 6'h09 : 6'h08;
            if ($urandom_range(1) == 1) begin
                w[25:21] = 5'd31;
            end
        end
        return w;
    endfunction

    function automatic fetchPkt_t randomPacket(input bit wantValid);
        fetchPkt_t f;
        expOut_t   m;
        f.valid = wantValid;
        f.vAddr = $urandom;
        f.originEnable = 4'($urandom);
        for (int i = 0; i < 4; i++) begin
            f.inst[i]        = randomInst();
            f.btbPredDest[i] = $urandom;
        end
        f.btbPredTake   = 4'($urandom);
        f.btbInstEnable = 4'($urandom);
        f.btbValidTake  = 1'($urandom);
        f.btbValidDest  = $urandom;
        f.delaySlotOnly = $urandom_range(7) == 0;
        f.hasException  = $urandom_range(15) == 0;
        f.excCode       = 5'($urandom);
        // about half agree with the btb
        if ($urandom_range(1) == 1) begin
            m = model(f);
            f.btbInstEnable = m.actEn;
            f.btbValidTake  = m.r.correctTake;
            f.btbValidDest  = m.r.correctDest;
        end
        return f;
    endfunction

    task automatic checkField(input string what, input logic [319:0] got,
                              input logic [319:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // books the sampled input and offers the next packet
    task automatic stepCycle(input bit offer);
        expOut_t   e;
        fetchPkt_t next;
        @(posedge clk);
        e = model(fetch);
        expQ.push_back(e);
        if (e.qValid) accepted++;
        if (creditReturn) returned++;
        modelCredit = modelCredit - int'(e.qValid) + int'(creditReturn);
        running = 1'b1;
        if (offer && modelCredit > 0 && $urandom_range(3) != 0) begin
            next = randomPacket(1'b1);
            sent++;
        end else begin
            next = randomPacket(1'b0);
        end
        fetch <= next;
    endtask

    // queue model returns one credit per cycle after a random wait
    always @(posedge clk) begin
        if (held > 0 && $urandom_range(1) == 1) begin
            creditReturn <= 1'b1;
            held--;
        end else begin
            creditReturn <= 1'b0;
        end
    end

    // ----------------------------------------
    // output check at mid-cycle
    // ----------------------------------------
    always @(negedge clk) begin : checkOutputs
        expOut_t e;
        if (running && expQ.size() > 0) begin
            e = expQ.pop_front();
            checkField("queueValid_o", queueValid, e.qValid);
            if (queueValid) begin
                received++;
                held++;
                checkField("queue inst", queuePkt.inst, e.q.inst);
                checkField("queue predTake", queuePkt.predTake, e.q.predTake);
                checkField("queue predDest", queuePkt.predDest, e.q.predDest);
                checkField("queue instEnable", queuePkt.instEnable, e.q.instEnable);
                checkField("queue instNum", queuePkt.instNum, e.q.instNum);
                checkField("queue basePC", queuePkt.basePC, e.q.basePC);
                checkField("queue hasException", queuePkt.hasException, e.q.hasException);
                checkField("queue excCode", queuePkt.excCode, e.q.excCode);
            end
            checkField("redirect flag", redirect.redirect, e.r.redirect);
            checkField("repairAction", redirect.repairAction, e.r.repairAction);
            checkField("redirect info", redirect, e.r);
            checkField("creditAvail_o", creditAvail, modelCredit != 0);
            assert (received - returned >= 0 && received - returned <= CREDITS) else begin
                errors++;
                $display("credit rule broken at %0t: %0d packets in flight",
                         $time, received - returned);
            end
        end
    end

    initial begin
        void'($urandom(33));
        clk          = 1'b0;
        arstN_i      = 1'b0;
        fetch        = '0;
        creditReturn = 1'b0;
        errors       = 0;
        sent         = 0;
        accepted     = 0;
        received     = 0;
        returned     = 0;
        held         = 0;
        modelCredit  = CREDITS;
        running      = 1'b0;
        repeat (5) @(posedge clk);
        arstN_i <= 1'b1;
        @(negedge clk);
        checkField("queueValid_o after reset", queueValid, 1'b0);
        checkField("redirect_o after reset", redirect, '0);
        checkField("creditAvail_o after reset", creditAvail, 1'b1);
        while (sent < PACKETS) begin
            stepCycle(1'b1);
        end
        // drain the queue model
        repeat (3) stepCycle(1'b0);
        while (modelCredit != CREDITS) begin
            stepCycle(1'b0);
        end
        @(posedge clk);
        assert (accepted == received && expQ.size() == 0) else begin
            errors++;
            $display("packets lost or duplicated: %0d accepted, %0d received",
                     accepted, received);
        end
        $display("run done: %0d packets sent, %0d errors", sent, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(PACKETS * PERIOD * 8);
        $display("timeout: run did not complete within %0d time units", PACKETS * PERIOD * 8);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
